// File: src/axi_pkg.sv
package axi_pkg;

	// AXI4 channel field widths
	localparam int AXI_DATA_WIDTH   = 64;
	localparam int AXI_ADDR_WIDTH   = 64;
	localparam int AXI_ID_WIDTH     = 4;
	localparam int AXI_LEN_WIDTH    = 8;
	localparam int AXI_SIZE_WIDTH   = 3;
	localparam int AXI_BURST_WIDTH  = 2;
	localparam int AXI_RESP_WIDTH   = 2;
	localparam int AXI_PROT_WIDTH   = 3;
	localparam int AXI_CACHE_WIDTH  = 4;
	localparam int AXI_QOS_WIDTH    = 4;
	localparam int AXI_REGION_WIDTH = 4;
	localparam int AXI_USER_WIDTH   = 1;

	localparam logic [AXI_BURST_WIDTH-1:0] BURST_INCR = 2'b01;

	localparam logic [AXI_RESP_WIDTH-1:0] RESP_OKAY   = 2'b00;
	localparam logic [AXI_RESP_WIDTH-1:0] RESP_SLVERR = 2'b10;

	// Byte lane within one data beat
	localparam int BEAT_OFFSET_WIDTH = $clog2(AXI_DATA_WIDTH / 8);
	localparam int WORD_ADDR_WIDTH   = AXI_ADDR_WIDTH - BEAT_OFFSET_WIDTH;

	// CPU access size, log2 of the byte count
	localparam int CPU_SIZE_WIDTH = 2;
	localparam logic [CPU_SIZE_WIDTH-1:0] CPU_SIZE_B = 2'd0;
	localparam logic [CPU_SIZE_WIDTH-1:0] CPU_SIZE_H = 2'd1;
	localparam logic [CPU_SIZE_WIDTH-1:0] CPU_SIZE_W = 2'd2;
	localparam logic [CPU_SIZE_WIDTH-1:0] CPU_SIZE_D = 2'd3;

	// Backing memory, power of two deep
	localparam int MEM_WORDS       = 256;
	localparam int MEM_INDEX_WIDTH = $clog2(MEM_WORDS);

endpackage

// File: src/axi_read_master.sv
module axi_read_master (
	input  logic                                   clk,
	input  logic                                   reset_n,
	input  logic                                   cpu_ar_valid_i,
	input  logic [axi_pkg::AXI_ID_WIDTH-1:0]       cpu_id_i,
	input  logic [axi_pkg::AXI_ADDR_WIDTH-1:0]     cpu_addr_i,
	input  logic [axi_pkg::AXI_LEN_WIDTH-1:0]      cpu_len_i,
	input  logic [axi_pkg::CPU_SIZE_WIDTH-1:0]     cpu_size_i,
	output logic                                   cpu_ar_ready_o,
	output logic                                   cpu_r_valid_o,
	output logic [axi_pkg::AXI_DATA_WIDTH-1:0]     cpu_r_data_o,
	output logic [axi_pkg::AXI_RESP_WIDTH-1:0]     cpu_r_resp_o,
	output logic                                   cpu_r_last_o,
	output logic [axi_pkg::BEAT_OFFSET_WIDTH-1:0]  beat_offset_o,
	output logic                                   axi_ar_valid_o,
	input  logic                                   axi_ar_ready_i,
	output logic [axi_pkg::AXI_ID_WIDTH-1:0]       axi_ar_id_o,
	output logic [axi_pkg::AXI_ADDR_WIDTH-1:0]     axi_ar_addr_o,
	output logic [axi_pkg::AXI_LEN_WIDTH-1:0]      axi_ar_len_o,
	output logic [axi_pkg::AXI_SIZE_WIDTH-1:0]     axi_ar_size_o,
	output logic [axi_pkg::AXI_BURST_WIDTH-1:0]    axi_ar_burst_o,
	output logic [axi_pkg::AXI_PROT_WIDTH-1:0]     axi_ar_prot_o,
	output logic [axi_pkg::AXI_USER_WIDTH-1:0]     axi_ar_user_o,
	output logic                                   axi_ar_lock_o,
	output logic [axi_pkg::AXI_CACHE_WIDTH-1:0]    axi_ar_cache_o,
	output logic [axi_pkg::AXI_QOS_WIDTH-1:0]      axi_ar_qos_o,
	output logic [axi_pkg::AXI_REGION_WIDTH-1:0]   axi_ar_region_o,
	output logic                                   axi_r_ready_o,
	input  logic                                   axi_r_valid_i,
	input  logic [axi_pkg::AXI_DATA_WIDTH-1:0]     axi_r_data_i,
	input  logic [axi_pkg::AXI_RESP_WIDTH-1:0]     axi_r_resp_i,
	input  logic                                   axi_r_last_i,
	input  logic [axi_pkg::AXI_ID_WIDTH-1:0]       axi_r_id_i,
	input  logic [axi_pkg::AXI_USER_WIDTH-1:0]     axi_r_user_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA
	} state_t;

	state_t state;
	state_t state_next;

	logic cpu_accept;
	logic ar_fire;
	logic r_fire;
	logic beat_bad;

	// Request held for the whole burst
	logic [axi_pkg::AXI_ID_WIDTH-1:0]          req_id;
	logic [axi_pkg::WORD_ADDR_WIDTH-1:0]       req_word;
	logic [axi_pkg::AXI_LEN_WIDTH-1:0]         req_len;
	logic [axi_pkg::CPU_SIZE_WIDTH-1:0]        req_size;
	logic [axi_pkg::BEAT_OFFSET_WIDTH-1:0]     req_offset;
	logic [axi_pkg::AXI_DATA_WIDTH-1:0]        req_mask;

	// Byte lanes covered by one access
	function automatic logic [axi_pkg::AXI_DATA_WIDTH-1:0] lane_mask(
		input logic [axi_pkg::CPU_SIZE_WIDTH-1:0]    size,
		input logic [axi_pkg::BEAT_OFFSET_WIDTH-1:0] offset
	);
		logic [axi_pkg::AXI_DATA_WIDTH-1:0] m;
		case (size)
			axi_pkg::CPU_SIZE_B: m = 64'h0000_0000_0000_00ff;
			axi_pkg::CPU_SIZE_H: m = 64'h0000_0000_0000_ffff;
			axi_pkg::CPU_SIZE_W: m = 64'h0000_0000_ffff_ffff;
			default:             m = '1;
		endcase
		return m << {offset, 3'b000};
	endfunction

	assign cpu_accept = cpu_ar_valid_i & cpu_ar_ready_o;
	assign ar_fire    = axi_ar_valid_o & axi_ar_ready_i;
	assign r_fire     = axi_r_valid_i & axi_r_ready_o;

	// Stray ID or poisoned RUSER turns the beat into an error
	assign beat_bad = (axi_r_id_i != req_id) | (|axi_r_user_i);

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: if (cpu_accept) state_next = ST_ADDR;
			ST_ADDR: if (ar_fire) state_next = ST_DATA;
			ST_DATA: if (r_fire && axi_r_last_i) state_next = ST_IDLE;
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state          <= ST_IDLE;
			cpu_ar_ready_o <= 1'b0;
		end else begin
			state          <= state_next;
			cpu_ar_ready_o <= (state_next == ST_IDLE);
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_accept) begin
			req_id     <= cpu_id_i;
			req_word   <= cpu_addr_i[axi_pkg::AXI_ADDR_WIDTH-1:axi_pkg::BEAT_OFFSET_WIDTH];
			req_len    <= cpu_len_i;
			req_size   <= cpu_size_i;
			req_offset <= cpu_addr_i[axi_pkg::BEAT_OFFSET_WIDTH-1:0];
			req_mask   <= lane_mask(cpu_size_i, cpu_addr_i[axi_pkg::BEAT_OFFSET_WIDTH-1:0]);
		end
	end

	assign axi_ar_valid_o  = (state == ST_ADDR);
	assign axi_r_ready_o   = (state == ST_DATA);
	assign axi_ar_id_o     = req_id;
	assign axi_ar_addr_o   = {req_word, {axi_pkg::BEAT_OFFSET_WIDTH{1'b0}}}; // Word aligned
	assign axi_ar_len_o    = req_len;
	assign axi_ar_size_o   = {1'b0, req_size};
	assign axi_ar_burst_o  = axi_pkg::BURST_INCR;
	assign axi_ar_prot_o   = '0;
	assign axi_ar_user_o   = '0;
	assign axi_ar_lock_o   = 1'b0;
	assign axi_ar_cache_o  = '0;
	assign axi_ar_qos_o    = '0;
	assign axi_ar_region_o = '0;
	assign beat_offset_o   = req_offset;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cpu_r_valid_o <= 1'b0;
			cpu_r_last_o  <= 1'b0;
			cpu_r_resp_o  <= '0;
		end else begin
			cpu_r_valid_o <= r_fire; // One pulse per beat
			cpu_r_last_o  <= r_fire & axi_r_last_i;
			if (r_fire)
				cpu_r_resp_o <= beat_bad ? axi_pkg::RESP_SLVERR : axi_r_resp_i;
		end
	end

	always_ff @(posedge clk) begin
		if (r_fire)
			cpu_r_data_o <= axi_r_data_i & req_mask;
	end

endmodule

// File: src/load_align.sv
module load_align (
	input  logic [axi_pkg::CPU_SIZE_WIDTH-1:0]    cpu_size_i,
	input  logic                                  cpu_signed_i,
	input  logic [axi_pkg::BEAT_OFFSET_WIDTH-1:0] beat_offset_i,
	input  logic [axi_pkg::AXI_DATA_WIDTH-1:0]    beat_data_i,
	output logic [axi_pkg::AXI_DATA_WIDTH-1:0]    load_data_o
);

	logic [axi_pkg::AXI_DATA_WIDTH-1:0] shifted;
	logic                               fill_bit;

	// Selected bytes down to lane 0
	assign shifted = beat_data_i >> {beat_offset_i, 3'b000};

	always_comb begin
		case (cpu_size_i)
			axi_pkg::CPU_SIZE_B: fill_bit = cpu_signed_i & shifted[7];
			axi_pkg::CPU_SIZE_H: fill_bit = cpu_signed_i & shifted[15];
			axi_pkg::CPU_SIZE_W: fill_bit = cpu_signed_i & shifted[31];
			default:             fill_bit = 1'b0;
		endcase
	end

	always_comb begin
		case (cpu_size_i)
			axi_pkg::CPU_SIZE_B: begin
				load_data_o = {{56{fill_bit}}, shifted[7:0]};
			end
			axi_pkg::CPU_SIZE_H: begin
				load_data_o = {{48{fill_bit}}, shifted[15:0]};
			end
			axi_pkg::CPU_SIZE_W: begin
				load_data_o = {{32{fill_bit}}, shifted[31:0]};
			end
			default: begin
				load_data_o = shifted; // Full doubleword, nothing to extend
			end
		endcase
	end

endmodule

// File: src/axi_rd_mem.sv
module axi_rd_mem (
	input  logic                                  clk,
	input  logic                                  reset_n,
	input  logic                                  axi_ar_valid_i,
	output logic                                  axi_ar_ready_o,
	input  logic [axi_pkg::AXI_ID_WIDTH-1:0]      axi_ar_id_i,
	input  logic [axi_pkg::AXI_ADDR_WIDTH-1:0]    axi_ar_addr_i,
	input  logic [axi_pkg::AXI_LEN_WIDTH-1:0]     axi_ar_len_i,
	input  logic                                  axi_r_ready_i,
	output logic                                  axi_r_valid_o,
	output logic [axi_pkg::AXI_DATA_WIDTH-1:0]    axi_r_data_o,
	output logic [axi_pkg::AXI_RESP_WIDTH-1:0]    axi_r_resp_o,
	output logic                                  axi_r_last_o,
	output logic [axi_pkg::AXI_ID_WIDTH-1:0]      axi_r_id_o,
	input  logic                                  mem_we_i,
	input  logic [axi_pkg::MEM_INDEX_WIDTH-1:0]   mem_waddr_i,
	input  logic [axi_pkg::AXI_DATA_WIDTH-1:0]    mem_wdata_i
);

	logic [axi_pkg::AXI_DATA_WIDTH-1:0] mem [axi_pkg::MEM_WORDS];

	logic                                burst_open;
	logic [axi_pkg::AXI_LEN_WIDTH-1:0]   beats_left; // Beats after the one on the bus
	logic [axi_pkg::WORD_ADDR_WIDTH-1:0] word_idx;

	logic                                ar_fire;
	logic                                r_fire;
	logic                                fetch;
	logic [axi_pkg::WORD_ADDR_WIDTH-1:0] fetch_idx;
	logic                                in_range;

	assign axi_ar_ready_o = ~burst_open;
	assign ar_fire        = axi_ar_valid_i & axi_ar_ready_o;
	assign r_fire         = axi_r_valid_o & axi_r_ready_i;
	assign axi_r_last_o   = (beats_left == '0);

	// New burst or next beat once the current one is taken
	assign fetch     = ar_fire | (r_fire & ~axi_r_last_o);
	assign fetch_idx = ar_fire ?
		axi_ar_addr_i[axi_pkg::AXI_ADDR_WIDTH-1:axi_pkg::BEAT_OFFSET_WIDTH] :
		word_idx + 1'b1;

	// Depth is a power of two, so any upper index bit means out of range
	assign in_range = ~|fetch_idx[axi_pkg::WORD_ADDR_WIDTH-1:axi_pkg::MEM_INDEX_WIDTH];

	always_ff @(posedge clk) begin
		if (mem_we_i)
			mem[mem_waddr_i] <= mem_wdata_i;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			burst_open    <= 1'b0;
			axi_r_valid_o <= 1'b0;
			axi_r_resp_o  <= '0;
			beats_left    <= '0;
		end else begin
			if (ar_fire) begin
				burst_open    <= 1'b1;
				axi_r_valid_o <= 1'b1;
				beats_left    <= axi_ar_len_i;
			end else if (r_fire) begin
				if (axi_r_last_o) begin
					burst_open    <= 1'b0;
					axi_r_valid_o <= 1'b0;
				end else begin
					beats_left <= beats_left - 1'b1;
				end
			end
			if (fetch)
				axi_r_resp_o <= in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire)
			axi_r_id_o <= axi_ar_id_i; // Echoed on every beat
		if (fetch) begin
			word_idx     <= fetch_idx;
			axi_r_data_o <= in_range ? mem[fetch_idx[axi_pkg::MEM_INDEX_WIDTH-1:0]] : '0;
		end
	end

endmodule

// File: src/axi_read_top.sv
module axi_read_top (
	input  logic                                 clk,
	input  logic                                 reset_n,
	input  logic                                 cpu_ar_valid_i,
	input  logic [axi_pkg::AXI_ID_WIDTH-1:0]     cpu_id_i,
	input  logic [axi_pkg::AXI_ADDR_WIDTH-1:0]   cpu_addr_i,
	input  logic [axi_pkg::AXI_LEN_WIDTH-1:0]    cpu_len_i,
	input  logic [axi_pkg::CPU_SIZE_WIDTH-1:0]   cpu_size_i,
	input  logic                                 cpu_signed_i,
	output logic                                 cpu_ar_ready_o,
	output logic                                 cpu_r_valid_o,
	output logic [axi_pkg::AXI_DATA_WIDTH-1:0]   cpu_r_data_o,
	output logic [axi_pkg::AXI_RESP_WIDTH-1:0]   cpu_r_resp_o,
	output logic                                 cpu_r_last_o,
	input  logic                                 mem_we_i,
	input  logic [axi_pkg::MEM_INDEX_WIDTH-1:0]  mem_waddr_i,
	input  logic [axi_pkg::AXI_DATA_WIDTH-1:0]   mem_wdata_i
);

	logic                                  ar_valid;
	logic                                  ar_ready;
	logic [axi_pkg::AXI_ID_WIDTH-1:0]      ar_id;
	logic [axi_pkg::AXI_ADDR_WIDTH-1:0]    ar_addr;
	logic [axi_pkg::AXI_LEN_WIDTH-1:0]     ar_len;
	logic                                  r_ready;
	logic                                  r_valid;
	logic [axi_pkg::AXI_DATA_WIDTH-1:0]    r_data;
	logic [axi_pkg::AXI_RESP_WIDTH-1:0]    r_resp;
	logic                                  r_last;
	logic [axi_pkg::AXI_ID_WIDTH-1:0]      r_id;
	logic [axi_pkg::AXI_DATA_WIDTH-1:0]    masked_beat;
	logic [axi_pkg::BEAT_OFFSET_WIDTH-1:0] beat_offset;

	logic [axi_pkg::CPU_SIZE_WIDTH-1:0]    req_size;
	logic                                  req_signed;

	// Extension rule of the open request
	always_ff @(posedge clk) begin
		if (cpu_ar_valid_i && cpu_ar_ready_o) begin
			req_size   <= cpu_size_i;
			req_signed <= cpu_signed_i;
		end
	end

	axi_read_master axi_read_master_inst (
		.clk(clk), .reset_n(reset_n),
		.cpu_ar_valid_i(cpu_ar_valid_i), .cpu_id_i(cpu_id_i), .cpu_addr_i(cpu_addr_i),
		.cpu_len_i(cpu_len_i), .cpu_size_i(cpu_size_i), .cpu_ar_ready_o(cpu_ar_ready_o),
		.cpu_r_valid_o(cpu_r_valid_o), .cpu_r_data_o(masked_beat),
		.cpu_r_resp_o(cpu_r_resp_o), .cpu_r_last_o(cpu_r_last_o), .beat_offset_o(beat_offset),
		.axi_ar_valid_o(ar_valid), .axi_ar_ready_i(ar_ready), .axi_ar_id_o(ar_id),
		.axi_ar_addr_o(ar_addr), .axi_ar_len_o(ar_len), .axi_ar_size_o(), .axi_ar_burst_o(),
		.axi_ar_prot_o(), .axi_ar_user_o(), .axi_ar_lock_o(), .axi_ar_cache_o(),
		.axi_ar_qos_o(), .axi_ar_region_o(),
		.axi_r_ready_o(r_ready), .axi_r_valid_i(r_valid), .axi_r_data_i(r_data),
		.axi_r_resp_i(r_resp), .axi_r_last_i(r_last), .axi_r_id_i(r_id), .axi_r_user_i('0)
	);

	load_align load_align_inst (
		.cpu_size_i(req_size), .cpu_signed_i(req_signed),
		.beat_offset_i(beat_offset), .beat_data_i(masked_beat), .load_data_o(cpu_r_data_o)
	);

	axi_rd_mem axi_rd_mem_inst (
		.clk(clk), .reset_n(reset_n),
		.axi_ar_valid_i(ar_valid), .axi_ar_ready_o(ar_ready), .axi_ar_id_i(ar_id),
		.axi_ar_addr_i(ar_addr), .axi_ar_len_i(ar_len),
		.axi_r_ready_i(r_ready), .axi_r_valid_o(r_valid), .axi_r_data_o(r_data),
		.axi_r_resp_o(r_resp), .axi_r_last_o(r_last), .axi_r_id_o(r_id),
		.mem_we_i(mem_we_i), .mem_waddr_i(mem_waddr_i), .mem_wdata_i(mem_wdata_i)
	);

endmodule

// File: testbench/axi_read_sva.sv
module axi_read_sva (
	input logic                                 clk,
	input logic                                 reset_n,
	input logic                                 ar_valid_i,
	input logic                                 ar_ready_i,
	input logic [axi_pkg::AXI_ID_WIDTH-1:0]     ar_id_i,
	input logic [axi_pkg::AXI_ADDR_WIDTH-1:0]   ar_addr_i,
	input logic [axi_pkg::AXI_LEN_WIDTH-1:0]    ar_len_i,
	input logic [axi_pkg::AXI_SIZE_WIDTH-1:0]   ar_size_i,
	input logic                                 r_valid_i,
	input logic                                 r_ready_i,
	input logic                                 cpu_r_valid_i
);

	// AR held with steady fields until the slave takes it
	ar_hold: assert property (
		@(posedge clk) disable iff (!reset_n)
		ar_valid_i && !ar_ready_i |=> ar_valid_i
			&& $stable(ar_addr_i) && $stable(ar_id_i)
			&& $stable(ar_len_i) && $stable(ar_size_i)
	) else $error("AR valid dropped or AR fields changed before ready");

	// R phase opens only once the address has been taken
	ar_r_exclusive: assert property (
		@(posedge clk) disable iff (!reset_n)
		r_ready_i |-> !ar_valid_i
			&& ($past(r_ready_i) || $past(ar_valid_i && ar_ready_i))
	) else $error("R ready high while AR request still pending");

	// One result cycle for each R handshake, one cycle later
	result_pulse: assert property (
		@(posedge clk) disable iff (!reset_n)
		cpu_r_valid_i == $past(r_valid_i && r_ready_i)
	) else $error("CPU result valid does not match the accepted R beats");

endmodule

// File: testbench/tb_axi_read.sv
module tb_axi_read;

	localparam int N_FULL    = 32;
	localparam int N_NARROW  = 64;
	localparam int N_BURST   = 24;
	localparam int N_RANGE   = 8;
	localparam int N_TIMING  = 16;
	localparam int MAX_BEATS = 8;
	localparam int REQ_CYCLES = MAX_BEATS + 6; // Beats plus handshake overhead
	localparam int CYCLE_LIMIT = 20 + axi_pkg::MEM_WORDS
		+ (N_FULL + N_NARROW + N_BURST + N_RANGE + N_TIMING) * REQ_CYCLES;

	logic                                 clk;
	logic                                 reset_n;
	logic                                 cpu_ar_valid_i;
	logic [axi_pkg::AXI_ID_WIDTH-1:0]     cpu_id_i;
	logic [axi_pkg::AXI_ADDR_WIDTH-1:0]   cpu_addr_i;
	logic [axi_pkg::AXI_LEN_WIDTH-1:0]    cpu_len_i;
	logic [axi_pkg::CPU_SIZE_WIDTH-1:0]   cpu_size_i;
	logic                                 cpu_signed_i;
	logic                                 cpu_ar_ready_o;
	logic                                 cpu_r_valid_o;
	logic [axi_pkg::AXI_DATA_WIDTH-1:0]   cpu_r_data_o;
	logic [axi_pkg::AXI_RESP_WIDTH-1:0]   cpu_r_resp_o;
	logic                                 cpu_r_last_o;
	logic                                 mem_we_i;
	logic [axi_pkg::MEM_INDEX_WIDTH-1:0]  mem_waddr_i;
	logic [axi_pkg::AXI_DATA_WIDTH-1:0]   mem_wdata_i;

	logic [63:0] model [axi_pkg::MEM_WORDS]; // Mirror of the slave memory
	logic [31:0] lfsr_state;
	int errors = 0;
	int checks = 0;
	int test_errors = 0;
	int test_requests = 0;
	int cycle_count = 0;

	axi_read_top axi_read_top_inst (.*);

	bind axi_read_master axi_read_sva axi_read_sva_inst (
		.clk(clk), .reset_n(reset_n),
		.ar_valid_i(axi_ar_valid_o), .ar_ready_i(axi_ar_ready_i),
		.ar_id_i(axi_ar_id_o), .ar_addr_i(axi_ar_addr_o),
		.ar_len_i(axi_ar_len_o), .ar_size_i(axi_ar_size_o),
		.r_valid_i(axi_r_valid_i), .r_ready_i(axi_r_ready_o),
		.cpu_r_valid_i(cpu_r_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	function automatic logic [63:0] word_index(input logic [63:0] addr, input int k);
		return {3'b000, addr[63:3]} + 64'(k);
	endfunction

	function automatic logic [1:0] expected_resp(input logic [63:0] addr, input int k);
		if (word_index(addr, k) < 64'(axi_pkg::MEM_WORDS))
			return axi_pkg::RESP_OKAY;
		return axi_pkg::RESP_SLVERR;
	endfunction

	function automatic logic [63:0] expected_data(
		input logic [63:0] addr,
		input int          k,
		input logic [1:0]  size,
		input logic        sgn
	);
		logic [63:0] idx;
		logic [63:0] v;
		logic [63:0] keep;
		logic [63:0] top;
		int          nbits;
		idx = word_index(addr, k);
		if (idx >= 64'(axi_pkg::MEM_WORDS))
			return '0;
		nbits = 8 << size;
		v = model[idx[axi_pkg::MEM_INDEX_WIDTH-1:0]] >> (int'(addr[2:0]) * 8);
		if (nbits < 64) begin
			keep = (64'd1 << nbits) - 64'd1;
			top  = keep ^ (keep >> 1); // Sign bit of the access
			v    = v & keep;
			if (sgn && ((v & top) != 64'd0))
				v = v | ~keep;
		end
		return v;
	endfunction

	function automatic void check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error @%0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endfunction

	task automatic report_test(input string name);
		$display("test %s: %0d requests, %0d errors", name, test_requests, errors - test_errors);
		test_errors   = errors;
		test_requests = 0;
	endtask

	task automatic fill_memory();
		logic [63:0] r;
		for (int w = 0; w < axi_pkg::MEM_WORDS; w++) begin
			@(posedge clk);
			r = take_bits(64);
			mem_we_i    <= 1'b1;
			mem_waddr_i <= w[axi_pkg::MEM_INDEX_WIDTH-1:0];
			mem_wdata_i <= r;
			model[w[axi_pkg::MEM_INDEX_WIDTH-1:0]] = r;
		end
		@(posedge clk);
		mem_we_i <= 1'b0;
	endtask

	task automatic run_request(
		input  logic [63:0] addr,
		input  logic [7:0]  len,
		input  logic [1:0]  size,
		input  logic        sgn,
		output int          latency
	);
		logic [63:0] r;
		int          beat;
		int          cycles;
		bit          done;
		@(posedge clk);
		while (!cpu_ar_ready_o)
			@(posedge clk);
		r = take_bits(4);
		cpu_ar_valid_i <= 1'b1;
		cpu_id_i       <= r[3:0];
		cpu_addr_i     <= addr;
		cpu_len_i      <= len;
		cpu_size_i     <= size;
		cpu_signed_i   <= sgn;
		@(posedge clk); // Acceptance edge
		cpu_ar_valid_i <= 1'b0;
		beat    = 0;
		cycles  = 0;
		done    = 1'b0;
		latency = 0;
		while (!done) begin
			@(posedge clk);
			cycles++;
			if (cpu_r_valid_o) begin
				if (beat == 0)
					latency = cycles;
				check_value("beat data", cpu_r_data_o, expected_data(addr, beat, size, sgn));
				check_value("beat resp", 64'(cpu_r_resp_o), 64'(expected_resp(addr, beat)));
				check_value("beat last", 64'(cpu_r_last_o), 64'(beat == int'(len)));
				beat++;
				done = cpu_r_last_o;
			end
			// Ready comes back together with the last result
			check_value("cpu ready", 64'(cpu_ar_ready_o), 64'(cycles == 3 + int'(len)));
		end
		check_value("beat count", 64'(beat), 64'(len) + 64'd1);
		test_requests++;
	endtask

	initial begin
		logic [63:0] r;
		logic [63:0] addr;
		logic [1:0]  size;
		int          nbytes;
		int          latency;
		lfsr_state     = 32'h76c0;
		reset_n        = 1'b0;
		cpu_ar_valid_i = 1'b0;
		cpu_id_i       = '0;
		cpu_addr_i     = '0;
		cpu_len_i      = '0;
		cpu_size_i     = '0;
		cpu_signed_i   = 1'b0;
		mem_we_i       = 1'b0;
		mem_waddr_i    = '0;
		mem_wdata_i    = '0;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;

		fill_memory();
		for (int i = 0; i < N_FULL; i++) begin
			r    = take_bits(8);
			addr = 64'(r[7:0]) << 3;
			run_request(addr, 8'd0, axi_pkg::CPU_SIZE_D, 1'b0, latency);
		end
		report_test("fill and full reads");

		for (int i = 0; i < N_NARROW; i++) begin
			r      = take_bits(14);
			size   = r[9:8];
			nbytes = 1 << size;
			addr   = (64'(r[7:0]) << 3) + 64'(int'(r[12:10]) % (9 - nbytes)); // Stay in word
			run_request(addr, 8'd0, size, r[13], latency);
		end
		report_test("narrow loads");

		for (int i = 0; i < N_BURST; i++) begin
			r    = take_bits(11);
			addr = 64'(int'(r[7:0]) % (axi_pkg::MEM_WORDS - MAX_BEATS)) << 3;
			run_request(addr, 8'(r[10:8]), axi_pkg::CPU_SIZE_D, 1'b0, latency);
		end
		report_test("bursts");

		// Start in the last four words, always run past the end
		for (int i = 0; i < N_RANGE; i++) begin
			r    = take_bits(4);
			addr = 64'(axi_pkg::MEM_WORDS - 1 - int'(r[1:0])) << 3;
			run_request(addr, 8'(4 + int'(r[3:2])), axi_pkg::CPU_SIZE_D, 1'b0, latency);
		end
		report_test("out of range");

		for (int i = 0; i < N_TIMING; i++) begin
			r    = take_bits(10);
			size = r[9:8];
			addr = 64'(r[7:0]) << 3;
			run_request(addr, 8'd0, size, 1'b1, latency);
			check_value("first beat latency", 64'(latency), 64'd3);
		end
		report_test("timing");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: build.f
src/axi_pkg.sv
src/axi_read_master.sv
src/load_align.sv
src/axi_rd_mem.sv
src/axi_read_top.sv
testbench/axi_read_sva.sv
testbench/tb_axi_read.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_axi_read -o sim_axi_read

output=$(./obj_dir/sim_axi_read)
echo "$output"

if grep -q "Finished with no errors" <<< "$output"; then
	exit 0
fi
exit 1
